//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it from the project root,
# and decide pass or fail from the printed pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module tb_ooo_core \
	-f sources.f \
	-o sim_tb_ooo_core \
	&& ./obj_dir/sim_tb_ooo_core | tee /dev/stderr | grep -qx '\*\*\* PASSED \*\*\*' \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }
exit 0

//--- sources.f
src/core_pkg.sv
src/dispatch_reg.sv
src/alu_lane.sv
src/rob.sv
src/ooo_core.sv
verif/tb_ooo_core.sv

//--- src/alu_lane.sv
/*
 * execution lane
 * single cycle alu ops plus a multiply that holds the lane for
 * MUL_CYCLES cycles, result broadcast as a one cycle pulse
 * MUL_CYCLES is expected to be 2 or more
 */

`timescale 1ns/100ps

module alu_lane #(
	parameter int MUL_CYCLES = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  core_pkg::lane_entry_t entry,
	output logic                  busy,
	output core_pkg::cdb_t        result
);

	import core_pkg::*;

	localparam int CNT_W = $clog2(MUL_CYCLES + 1);

	logic             is_mul;
	logic [XLEN-1:0]  alu_out;

	// multiply countdown state
	logic [CNT_W-1:0] mul_count;
	logic [XLEN-1:0]  mul_a;
	logic [XLEN-1:0]  mul_b;
	rob_idx_t         mul_idx;
	logic [XLEN-1:0]  mul_low;

	// broadcast register
	logic             res_valid;
	rob_idx_t         res_idx;
	logic [XLEN-1:0]  res_data;

	assign is_mul = entry.slot.valid && (entry.slot.op == alu_mul);

	// high from the cycle a mul shows up until dispatch may refill the lane
	// last countdown cycle is free since the new entry lands one edge later
	assign busy = is_mul || (mul_count > CNT_W'(1));

	//////////////////////////////////////////////////
	// single cycle ops
	//////////////////////////////////////////////////

	always_comb begin
		case (entry.slot.op)
			alu_add: alu_out = entry.slot.opa + entry.slot.opb;
			alu_sub: alu_out = entry.slot.opa - entry.slot.opb;
			alu_and: alu_out = entry.slot.opa & entry.slot.opb;
			alu_or:  alu_out = entry.slot.opa | entry.slot.opb;
			alu_xor: alu_out = entry.slot.opa ^ entry.slot.opb;
			// signed compare
			alu_slt: alu_out = {{(XLEN-1){1'b0}},
				($signed(entry.slot.opa) < $signed(entry.slot.opb))};
			default: alu_out = '0;
		endcase
	end

	// low half of the product only
	assign mul_low = mul_a * mul_b;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			res_valid <= 1'b0;
			mul_count <= '0;
		end else begin
			res_valid <= 1'b0;
			if (mul_count != '0) begin
				mul_count <= mul_count - 1'b1;
			end
			// count ending, release the product
			if (mul_count == CNT_W'(1)) begin
				res_valid <= 1'b1;
			end
			if (is_mul) begin
				mul_count <= CNT_W'(MUL_CYCLES - 1);
			end else if (entry.slot.valid) begin
				res_valid <= 1'b1;
			end
		end
	end

	// operands and result data
	always_ff @(posedge clock) begin
		if (is_mul) begin
			mul_a   <= entry.slot.opa;
			mul_b   <= entry.slot.opb;
			mul_idx <= entry.rob_idx;
		end
		if (entry.slot.valid && !is_mul) begin
			res_data <= alu_out;
			res_idx  <= entry.rob_idx;
		end else if (mul_count == CNT_W'(1)) begin
			res_data <= mul_low;
			res_idx  <= mul_idx;
		end
	end

	assign result.valid   = res_valid;
	assign result.rob_idx = res_idx;
	assign result.result  = res_data;
	assign result.spare   = 1'b0;

endmodule

//--- src/core_pkg.sv
/*
 * core package
 * widths, opcode and status encodings, and the packed structs that
 * carry instructions from dispatch through the lanes to commit
 */

package core_pkg;

	//////////////////////////////////////////////////
	// widths and default sizes
	//////////////////////////////////////////////////

	// data path width
	parameter int XLEN = 32;

	// issue width and rob size, top level may override
	parameter int DEFAULT_WAYS = 2;
	// power of two, up to 32
	parameter int DEFAULT_ROB_DEPTH = 16;

	// 5 bits covers any legal rob depth
	typedef logic [4:0] rob_idx_t;
	typedef logic [4:0] reg_idx_t;

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_mul
	} alu_op_e;

	// core status, latched by the rob
	typedef enum logic [1:0] {
		no_error,
		halted_on_wfi,
		illegal_inst
	} error_status_e;

	//////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////

	// decoded instruction with operand values already read
	typedef struct packed {
		logic            valid;
		alu_op_e         op;
		logic [XLEN-1:0] opa;
		logic [XLEN-1:0] opb;
		reg_idx_t        dest_reg;
		logic            reg_write;
		logic            halt;
		logic            illegal;
	} dispatch_slot_t;

	// what a lane sees, instruction stamped with its rob slot
	typedef struct packed {
		dispatch_slot_t slot;
		rob_idx_t       rob_idx;
	} lane_entry_t;

	// result broadcast from a lane
	typedef struct packed {
		logic            valid;
		rob_idx_t        rob_idx;
		logic [XLEN-1:0] result;
		logic            spare;
	} cdb_t;

	// retired instruction
	typedef struct packed {
		logic            valid;
		reg_idx_t        dest_reg;
		logic            reg_write;
		logic [XLEN-1:0] data;
	} commit_t;

endpackage

//--- src/dispatch_reg.sv
/*
 * dispatch register
 * single stall point of the core: takes a bundle when the rob has
 * room and every lane is idle, stamps each valid slot with its rob
 * index and presents the result to the lanes and the rob
 */

`timescale 1ns/100ps

module dispatch_reg #(
	parameter int WAYS      = 2,
	parameter int ROB_DEPTH = 16
) (
	input  logic                                       clock,
	input  logic                                       reset,
	input  core_pkg::dispatch_slot_t [WAYS-1:0]        dispatch_bundle,
	input  core_pkg::rob_idx_t                         rob_tail,
	input  logic [$clog2(ROB_DEPTH):0]                 rob_num_free,
	input  logic [WAYS-1:0]                            lane_busy,
	input  logic                                       rob_stopped,
	output logic                                       dispatch_ready,
	output core_pkg::lane_entry_t [WAYS-1:0]           lane_entries
);

	import core_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = IDX_W + 1;

	lane_entry_t [WAYS-1:0] stamped;
	logic [IDX_W-1:0]       offset;
	logic [IDX_W-1:0]       slot_idx;

	//////////////////////////////////////////////////
	// stall decision
	//////////////////////////////////////////////////

	// room for a full bundle, no multiply in flight, no halt seen
	assign dispatch_ready = (rob_num_free >= CNT_W'(WAYS)) &&
		!(|lane_busy) && !rob_stopped;

	//////////////////////////////////////////////////
	// rob index stamping
	//////////////////////////////////////////////////

	// slot i gets tail plus i, counting valid slots only
	// so a hole in the bundle does not leave a dead rob entry
	always_comb begin
		offset   = '0;
		slot_idx = '0;
		for (int i = 0; i < WAYS; i++) begin
			// wraps at rob depth through the narrow sum
			slot_idx           = rob_tail[IDX_W-1:0] + offset;
			stamped[i].slot    = dispatch_bundle[i];
			stamped[i].rob_idx = rob_idx_t'(slot_idx);
			if (dispatch_bundle[i].valid) begin
				offset = offset + 1'b1;
			end
		end
	end

	// id/ex style register, bubbles when not taking a bundle
	always_ff @(posedge clock) begin
		if (reset || !dispatch_ready) begin
			lane_entries <= '0;
		end else begin
			lane_entries <= stamped;
		end
	end

endmodule

//--- src/ooo_core.sv
/*
 * out-of-order core, back half
 * dispatch register feeding WAYS execution lanes whose results
 * broadcast to a reorder buffer that retires in program order
 */

`timescale 1ns/100ps

module ooo_core #(
	parameter int WAYS       = core_pkg::DEFAULT_WAYS,
	parameter int ROB_DEPTH  = core_pkg::DEFAULT_ROB_DEPTH,
	parameter int MUL_CYCLES = 4
) (
	input  logic                                clock,
	input  logic                                reset,
	input  core_pkg::dispatch_slot_t [WAYS-1:0] dispatch_bundle,
	output logic                                dispatch_ready,
	output core_pkg::commit_t [WAYS-1:0]        commit_bundle,
	output logic [3:0]                          completed_insts,
	output core_pkg::error_status_e             error_status
);

	import core_pkg::*;

	// dispatch to lanes and rob
	lane_entry_t [WAYS-1:0]      lane_entries;
	logic [WAYS-1:0]             lane_busy;
	// result broadcast
	cdb_t [WAYS-1:0]             results;
	// rob back to dispatch
	rob_idx_t                    rob_tail;
	logic [$clog2(ROB_DEPTH):0]  rob_num_free;
	logic                        rob_stopped;

	//////////////////////////////////////////////////
	// dispatch
	//////////////////////////////////////////////////

	dispatch_reg #(
		.WAYS      (WAYS),
		.ROB_DEPTH (ROB_DEPTH)
	) i_dispatch_reg (
		.clock           (clock),
		.reset           (reset),
		.dispatch_bundle (dispatch_bundle),
		.rob_tail        (rob_tail),
		.rob_num_free    (rob_num_free),
		.lane_busy       (lane_busy),
		.rob_stopped     (rob_stopped),
		.dispatch_ready  (dispatch_ready),
		.lane_entries    (lane_entries)
	);

	//////////////////////////////////////////////////
	// execution lanes, one per slot
	//////////////////////////////////////////////////

	for (genvar i = 0; i < WAYS; i++) begin : g_lane
		alu_lane #(
			.MUL_CYCLES (MUL_CYCLES)
		) i_alu_lane (
			.clock  (clock),
			.reset  (reset),
			.entry  (lane_entries[i]),
			.busy   (lane_busy[i]),
			.result (results[i])
		);
	end

	//////////////////////////////////////////////////
	// reorder buffer
	//////////////////////////////////////////////////

	rob #(
		.WAYS      (WAYS),
		.ROB_DEPTH (ROB_DEPTH)
	) i_rob (
		.clock           (clock),
		.reset           (reset),
		.alloc           (lane_entries),
		.results         (results),
		.tail            (rob_tail),
		.num_free        (rob_num_free),
		.stopped         (rob_stopped),
		.commit_bundle   (commit_bundle),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

endmodule

//--- src/rob.sv
/*
 * reorder buffer
 * circular buffer filled in program order from the dispatch register,
 * marked done by lane results, retiring up to WAYS entries per cycle
 * from the head; halt or illegal stops commit and sets the status
 */

`timescale 1ns/100ps

module rob #(
	parameter int WAYS      = 2,
	parameter int ROB_DEPTH = 16
) (
	input  logic                                 clock,
	input  logic                                 reset,
	input  core_pkg::lane_entry_t [WAYS-1:0]     alloc,
	input  core_pkg::cdb_t [WAYS-1:0]            results,
	output core_pkg::rob_idx_t                   tail,
	output logic [$clog2(ROB_DEPTH):0]           num_free,
	output logic                                 stopped,
	output core_pkg::commit_t [WAYS-1:0]         commit_bundle,
	output logic [3:0]                           completed_insts,
	output core_pkg::error_status_e              error_status
);

	import core_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = IDX_W + 1;

	// pointers and occupancy
	logic [IDX_W-1:0] head_reg;
	logic [IDX_W-1:0] tail_reg;
	logic [IDX_W-1:0] tail_next;
	logic [CNT_W-1:0] free_reg;
	logic [CNT_W-1:0] free_next;
	logic [CNT_W-1:0] used;
	logic             stopped_reg;
	error_status_e    status_reg;

	// entry storage
	logic [ROB_DEPTH-1:0] ent_done;
	logic [ROB_DEPTH-1:0] ent_reg_write;
	logic [ROB_DEPTH-1:0] ent_halt;
	logic [ROB_DEPTH-1:0] ent_illegal;
	reg_idx_t             ent_dest [ROB_DEPTH];
	logic [XLEN-1:0]      ent_data [ROB_DEPTH];

	logic [CNT_W-1:0] n_alloc;
	logic [CNT_W-1:0] n_commit;
	logic             halt_hit;
	logic             illegal_hit;

	//////////////////////////////////////////////////
	// allocation side
	//////////////////////////////////////////////////

	always_comb begin
		n_alloc = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (alloc[i].slot.valid) begin
				n_alloc = n_alloc + 1'b1;
			end
		end
	end

	// dispatch stamps against the tail after this cycle's allocations
	assign tail_next = tail_reg + n_alloc[IDX_W-1:0];
	assign tail      = rob_idx_t'(tail_next);
	assign free_next = free_reg - n_alloc + n_commit;
	assign num_free  = free_next;
	assign used      = CNT_W'(ROB_DEPTH) - free_reg;

	//////////////////////////////////////////////////
	// in-order commit from the head
	//////////////////////////////////////////////////

	always_comb begin
		logic             going;
		logic [IDX_W-1:0] idx;
		going       = !stopped_reg;
		n_commit    = '0;
		halt_hit    = 1'b0;
		illegal_hit = 1'b0;
		for (int i = 0; i < WAYS; i++) begin
			idx              = head_reg + IDX_W'(i);
			commit_bundle[i] = '0;
			// occupied and finished, stop at the first gap
			if (going && (CNT_W'(i) < used) && ent_done[idx]) begin
				commit_bundle[i].valid     = 1'b1;
				commit_bundle[i].dest_reg  = ent_dest[idx];
				commit_bundle[i].reg_write = ent_reg_write[idx] &&
					!ent_halt[idx] && !ent_illegal[idx];
				commit_bundle[i].data      = ent_data[idx];
				n_commit                   = n_commit + 1'b1;
				// younger slots wait forever behind a halt
				if (ent_halt[idx] || ent_illegal[idx]) begin
					going       = 1'b0;
					halt_hit    = ent_halt[idx];
					illegal_hit = ent_illegal[idx];
				end
			end else begin
				going = 1'b0;
			end
		end
	end

	assign completed_insts = 4'(n_commit);
	assign stopped         = stopped_reg;
	assign error_status    = status_reg;

	//////////////////////////////////////////////////
	// state update
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head_reg    <= '0;
			tail_reg    <= '0;
			free_reg    <= CNT_W'(ROB_DEPTH);
			stopped_reg <= 1'b0;
			status_reg  <= no_error;
			ent_done    <= '0;
		end else begin
			head_reg <= head_reg + n_commit[IDX_W-1:0];
			tail_reg <= tail_next;
			free_reg <= free_next;
			// illegal outranks halt on the same entry
			if (illegal_hit) begin
				stopped_reg <= 1'b1;
				status_reg  <= illegal_inst;
			end else if (halt_hit) begin
				stopped_reg <= 1'b1;
				status_reg  <= halted_on_wfi;
			end
			for (int i = 0; i < WAYS; i++) begin
				if (alloc[i].slot.valid) begin
					ent_done[alloc[i].rob_idx[IDX_W-1:0]] <= 1'b0;
				end
			end
			// results never target an entry allocated this edge
			for (int i = 0; i < WAYS; i++) begin
				if (results[i].valid) begin
					ent_done[results[i].rob_idx[IDX_W-1:0]] <= 1'b1;
				end
			end
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < WAYS; i++) begin
			if (alloc[i].slot.valid) begin
				ent_dest[alloc[i].rob_idx[IDX_W-1:0]]      <= alloc[i].slot.dest_reg;
				ent_reg_write[alloc[i].rob_idx[IDX_W-1:0]] <= alloc[i].slot.reg_write;
				ent_halt[alloc[i].rob_idx[IDX_W-1:0]]      <= alloc[i].slot.halt;
				ent_illegal[alloc[i].rob_idx[IDX_W-1:0]]   <= alloc[i].slot.illegal;
			end
		end
		for (int i = 0; i < WAYS; i++) begin
			if (results[i].valid) begin
				ent_data[results[i].rob_idx[IDX_W-1:0]] <= results[i].result;
			end
		end
	end

endmodule

//--- verif/core_trace.txt
// header: bundles commits final_status | bundle: per slot valid op opa opb dest_reg reg_write halt illegal
// commit: dest_reg reg_write data | op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 mul | status 1 halt 2 illegal
// run 1: alu mix, multiplies finishing out of order, rob index wrap, ends on a halt
0a 11 1
1 0 00000005 00000003 01 1 0 0  1 1 00000010 00000020 02 1 0 0
1 2 f0f0f0f0 0ff00ff0 03 1 0 0  1 3 12340000 00005678 04 1 0 0
1 4 aaaaaaaa 55555555 05 1 0 0  1 5 ffffffff 00000001 06 1 0 0
1 6 00001234 00005678 07 1 0 0  1 0 00000064 00000001 08 1 0 0
1 5 00000001 ffffffff 09 1 0 0  1 1 00000000 00000001 0a 1 0 0
1 6 ffffffff ffffffff 0b 1 0 0  1 6 00010001 00010001 0c 1 0 0
1 0 7fffffff 00000001 0d 1 0 0  1 5 80000000 7fffffff 0e 1 0 0
1 4 12345678 ffffffff 0f 1 0 0  1 2 deadbeef 0000ffff 10 0 0 0
1 0 00000000 00000000 00 0 1 0  1 0 00000001 00000001 11 1 0 0
1 0 00000002 00000003 12 1 0 0  0 0 00000000 00000000 00 0 0 0
// expected commits, nothing younger than the halt retires
01 1 00000008
02 1 fffffff0
03 1 00f000f0
04 1 12345678
05 1 ffffffff
06 1 00000001
07 1 06260060
08 1 00000065
09 1 00000000
0a 1 ffffffff
0b 1 00000001
0c 1 00020001
0d 1 80000000
0e 1 00000001
0f 1 edcba987
10 0 0000beef
00 0 00000000
// run 2: illegal behind a multiply in the same bundle
02 02 2
1 6 00000003 00000007 01 1 0 0  1 0 00000000 00000000 00 1 0 1
1 0 00000001 00000001 02 1 0 0  1 0 00000002 00000002 03 1 0 0
01 1 00000015
00 0 00000000
// end of runs
00 00 0

//--- verif/tb_ooo_core.sv
/*
 * testbench for the out-of-order core back half
 * reads runs of bundles and expected commits from the trace, feeds the
 * bundles through dispatch_ready with random idle gaps, and checks
 * every retired slot, the per-cycle count, the dispatch stall behind
 * a multiply and the final status
 */

`timescale 1ns/100ps

module tb_ooo_core;

	import core_pkg::*;

	localparam int WAYS         = DEFAULT_WAYS;
	// default multiply latency of the core
	localparam int MUL_CYCLES   = 4;
	localparam int SLOT_WORDS   = 8;
	localparam int COMMIT_WORDS = 3;
	localparam int TRACE_WORDS  = 1024;
	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 4;
	// quiet cycles after the last expected commit
	localparam int DRAIN_CYCLES = 16;

	logic                      clock;
	logic                      reset;
	dispatch_slot_t [WAYS-1:0] dispatch_bundle;
	logic                      dispatch_ready;
	commit_t [WAYS-1:0]        commit_bundle;
	logic [3:0]                completed_insts;
	error_status_e             error_status;

	// trace image and the current run
	logic [31:0]               trace_mem [TRACE_WORDS];
	dispatch_slot_t [WAYS-1:0] bundle_q [$];
	commit_t                   exp_commits [$];

	integer seed;
	logic   monitor_on;
	logic   run_done;
	int     commits_seen;
	// edges left in which dispatch must stay closed
	int     mul_hold;

	ooo_core i_ooo_core (
		.clock           (clock),
		.reset           (reset),
		.dispatch_bundle (dispatch_bundle),
		.dispatch_ready  (dispatch_ready),
		.commit_bundle   (commit_bundle),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	//////////////////////////////////////////////////
	// failure and compare tasks
	//////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_commit(input string name, input commit_t expected,
		input commit_t actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h, actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h, actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_status(input error_status_e expected, input error_status_e actual);
		if (actual !== expected) begin
			$display("** Error: error_status expected %h, actual %h", expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_ready(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error: dispatch_ready expected %h, actual %h", expected, actual);
			stop_with_failure();
		end
	endtask

	//////////////////////////////////////////////////
	// trace parsing
	//////////////////////////////////////////////////

	// one slot, eight words in trace column order
	function automatic dispatch_slot_t slot_at(input int base);
		dispatch_slot_t slot;
		slot.valid     = trace_mem[base][0];
		slot.op        = alu_op_e'(trace_mem[base + 1][2:0]);
		slot.opa       = trace_mem[base + 2];
		slot.opb       = trace_mem[base + 3];
		slot.dest_reg  = trace_mem[base + 4][4:0];
		slot.reg_write = trace_mem[base + 5][0];
		slot.halt      = trace_mem[base + 6][0];
		slot.illegal   = trace_mem[base + 7][0];
		return slot;
	endfunction

	// walk the run headers, zero header ends the list
	function automatic int count_bundles();
		int ptr;
		int total;
		ptr   = 0;
		total = 0;
		while (ptr < TRACE_WORDS - 3 && trace_mem[ptr] != 0) begin
			total += int'(trace_mem[ptr]);
			ptr += 3 + int'(trace_mem[ptr]) * WAYS * SLOT_WORDS +
				int'(trace_mem[ptr + 1]) * COMMIT_WORDS;
		end
		return total;
	endfunction

	// any valid multiply in a bundle
	function automatic logic has_mul(input dispatch_slot_t [WAYS-1:0] bundle);
		logic found;
		found = 1'b0;
		for (int i = 0; i < WAYS; i++) begin
			if (bundle[i].valid && bundle[i].op == alu_mul) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic load_run(input int base, input int nb, input int nc);
		dispatch_slot_t [WAYS-1:0] bundle;
		commit_t                   expected;
		int                        p;
		bundle_q.delete();
		exp_commits.delete();
		p = base;
		for (int b = 0; b < nb; b++) begin
			for (int i = 0; i < WAYS; i++) begin
				bundle[i] = slot_at(p);
				p += SLOT_WORDS;
			end
			bundle_q.push_back(bundle);
		end
		// commit stream in program order
		for (int k = 0; k < nc; k++) begin
			expected           = '0;
			expected.valid     = 1'b1;
			expected.dest_reg  = trace_mem[p][4:0];
			expected.reg_write = trace_mem[p + 1][0];
			expected.data      = trace_mem[p + 2];
			exp_commits.push_back(expected);
			p += COMMIT_WORDS;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic apply_reset();
		monitor_on      <= 1'b0;
		reset           <= 1'b1;
		dispatch_bundle <= '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset      <= 1'b0;
		monitor_on <= 1'b1;
	endtask

	// hold each bundle until an edge with dispatch_ready high
	task automatic drive_run();
		int   gap;
		logic accepted;
		while (bundle_q.size() > 0 && !run_done) begin
			gap = $unsigned($random(seed)) % 4;
			dispatch_bundle <= '0;
			repeat (gap) @(posedge clock);
			dispatch_bundle <= bundle_q.pop_front();
			accepted = 1'b0;
			// a stopped core never takes the rest
			while (!accepted && !run_done) begin
				@(posedge clock);
				accepted = dispatch_ready;
			end
		end
		dispatch_bundle <= '0;
	endtask

	task automatic await_commits(input int nc);
		while (commits_seen < nc) begin
			@(posedge clock);
		end
		// anything retiring now is past the stream
		repeat (DRAIN_CYCLES) @(posedge clock);
	endtask

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, commits stopped arriving", cycles);
		stop_with_failure();
	endtask

	//////////////////////////////////////////////////
	// commit monitor
	//////////////////////////////////////////////////

	always @(posedge clock) begin : commit_monitor
		int n_valid;
		n_valid = 0;
		if (!monitor_on) begin
			commits_seen = 0;
		end else begin
			// slot 0 is older than slot 1
			for (int i = 0; i < WAYS; i++) begin
				if (commit_bundle[i].valid) begin
					n_valid++;
					if (commits_seen >= exp_commits.size()) begin
						$display("commit slot %0d retired an instruction %s", i,
							"past the expected stream");
						stop_with_failure();
					end else begin
						check_commit($sformatf("commit_bundle[%0d]", i),
							exp_commits[commits_seen], commit_bundle[i]);
						commits_seen++;
					end
				end
			end
			check_count("completed_insts", 4'(n_valid), completed_insts);
		end
	end

	// a multiply holds its lane, so dispatch stays closed behind it
	always @(posedge clock) begin : ready_monitor
		if (!monitor_on) begin
			mul_hold = 0;
		end else if (mul_hold > 0) begin
			check_ready(1'b0, dispatch_ready);
			mul_hold--;
		end else if (dispatch_ready && has_mul(dispatch_bundle)) begin
			mul_hold = MUL_CYCLES - 1;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin : main_sequence
		int            ptr;
		int            nb;
		int            nc;
		int            runs;
		error_status_e exp_status;
		reset           <= 1'b1;
		dispatch_bundle <= '0;
		monitor_on      <= 1'b0;
		run_done = 1'b0;
		seed     = 32'he167;
		$readmemh("verif/core_trace.txt", trace_mem);
		fork
			run_watchdog(count_bundles() * 20 + 200);
		join_none
		ptr  = 0;
		runs = 0;
		while (trace_mem[ptr] != 0) begin
			nb         = int'(trace_mem[ptr]);
			nc         = int'(trace_mem[ptr + 1]);
			exp_status = error_status_e'(trace_mem[ptr + 2][1:0]);
			load_run(ptr + 3, nb, nc);
			ptr += 3 + nb * WAYS * SLOT_WORDS + nc * COMMIT_WORDS;
			apply_reset();
			run_done = 1'b0;
			fork
				drive_run();
				begin
					await_commits(nc);
					check_status(exp_status, error_status);
					run_done = 1'b1;
				end
			join
			runs++;
		end
		if (runs > 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("trace file held no runs to check");
			stop_with_failure();
		end
	end

endmodule
